// File: common/gba_macros.svh
// Screen geometry, raster timing, pixel divider and flash marker constants
`ifndef GBA_MACROS_SVH
`define GBA_MACROS_SVH

// ====================
// Visible screen
// ====================
`define GBA_SCREEN_W      240           // Active pixels per line
`define GBA_SCREEN_H      160           // Active lines per frame
`define GBA_FRAME_PIXELS  38400         // Framebuffer depth, 240*160
`define GBA_LAST_PIXEL    38399         // Write here closes a frame

// ====================
// Raster
// ====================
`define GBA_RASTER_SIZE   256           // Steps per line and lines per frame
`define GBA_PIX_DIV       4             // clk_sys cycles per pixel step
`define GBA_HS_START      244           // Column where hs rises
`define GBA_HS_END        252           // Column where hs falls
`define GBA_VS_START      163           // Line where vs rises
`define GBA_VS_END        166           // Line where vs falls
`define GBA_VSYNC_STRETCH 4             // Frame-end pulse length in cycles

// Save-type tag that the loader looks for inside a ROM image
`define GBA_FLASH_MARK    "FLASH1M_V"

`endif

// File: common/loader_pkg.sv
// Loader types: download stream, BIOS word write and cartridge info
package loader_pkg;

	// ====================
	// Download stream from the host side
	// ====================
	typedef struct packed {
		logic        active;    // Download in progress
		logic [7:0]  index;     // 0 = BIOS, all ones = codes, else cartridge
		logic [26:0] addr;      // Byte address of the halfword
		logic [15:0] data;      // Low byte comes first in the image
		logic        wr;        // One strobe per halfword
	} dl_stream_t;

	// Packed 32-bit BIOS write towards the core
	typedef struct packed {
		logic [11:0] addr;      // Word address
		logic [31:0] data;
		logic        wr;        // Single-cycle pulse
	} bios_write_t;

	// Facts gathered while a cartridge streams by
	typedef struct packed {
		logic        flash_1m;      // Marker string seen in the image
		logic [24:0] max_pak_addr;  // Last word address of the image
	} cart_info_t;

endpackage

// File: common/video_pkg.sv
// Video types: colour, pixel write, raster state and display output
package video_pkg;

	// 15-bit colour as the core writes it, red in the top bits
	typedef struct packed {
		logic [4:0] r;
		logic [4:0] g;
		logic [4:0] b;
	} rgb555_t;

	// Framebuffer write from the console core
	typedef struct packed {
		logic [15:0] addr;      // Row-major pixel index
		rgb555_t     data;
		logic        we;
	} pixel_write_t;

	// ====================
	// Raster and output
	// ====================
	typedef struct packed {
		logic ce_pix;           // One cycle per pixel step
		logic hs;
		logic vs;
		logic hbl;
		logic vbl;
	} raster_t;

	typedef struct packed {
		raster_t    raster;
		logic       de;         // Not in either blank
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} video_out_t;

endpackage

// File: rtl/gba_frontend.sv
// gba_frontend: top level joining the loader and display blocks
`timescale 1ns/1ps

module gba_frontend
	import loader_pkg::*;
	import video_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  dl_stream_t   dl,
	input  pixel_write_t pix_in,
	input  logic         desaturate,
	output bios_write_t  bios,
	output cart_info_t   cart,
	output logic         cart_loading,
	output video_out_t   video
);

	logic [15:0] rd_addr;       // Raster read address into the framebuffer
	rgb555_t     rd_data;
	raster_t     raster;        // Timing before the colour stage
	rgb555_t     color;

	// ====================
	// Loader
	// ====================
	download_router download_router_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl           (dl),
		.bios         (bios),
		.cart_loading (cart_loading)
	);

	cart_inspector cart_inspector_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl           (dl),
		.cart_loading (cart_loading),   // Registered kind flag from the router
		.cart         (cart)
	);

	// ====================
	// Display
	// ====================
	frame_buffer frame_buffer_inst (
		.clk_sys (clk_sys),
		.pix_in  (pix_in),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	video_timing video_timing_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.pix_in  (pix_in),              // Watched for the frame-end write
		.rd_data (rd_data),
		.rd_addr (rd_addr),
		.raster  (raster),
		.color   (color)
	);

	color_adjust color_adjust_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.desaturate (desaturate),
		.raster     (raster),
		.color      (color),
		.video      (video)
	);

endmodule

// File: rtl/loader/cart_inspector.sv
// cart_inspector: cartridge end address capture and flash marker search
`timescale 1ns/1ps
`include "gba_macros.svh"

module cart_inspector
	import loader_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  dl_stream_t dl,
	input  logic       cart_loading,
	output cart_info_t cart
);

	localparam logic [71:0] FLASH_MARK = `GBA_FLASH_MARK;

	logic        loading_d;         // cart_loading one cycle back
	logic        flash_1m;
	logic [24:0] max_pak_addr;
	logic [63:0] hist;              // Last eight stream bytes, newest low
	logic        lo_match;
	logic        hi_match;

	// Marker ending on the low byte, then on the high byte of this halfword
	assign lo_match = ({hist, dl.data[7:0]} == FLASH_MARK);
	assign hi_match = ({hist[55:0], dl.data[7:0], dl.data[15:8]} == FLASH_MARK);

	// ====================
	// Edge tracking and flag
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			loading_d <= 1'b0;
			flash_1m  <= 1'b0;
		end else begin
			loading_d <= cart_loading;
			if (~loading_d & cart_loading) flash_1m <= 1'b0;  // New cart starts clean
			if (cart_loading & dl.wr & (lo_match | hi_match)) flash_1m <= 1'b1;
		end
	end

	// Byte history and end address
	always_ff @(posedge clk_sys) begin
		if (cart_loading & dl.wr) begin
			hist <= {hist[47:0], dl.data[7:0], dl.data[15:8]};  // Two bytes per strobe
		end
		if (loading_d & ~cart_loading) begin
			max_pak_addr <= dl.addr[26:2];  // Word address of the last data
		end
	end

	assign cart = '{
		flash_1m:     flash_1m,
		max_pak_addr: max_pak_addr
	};

endmodule

// File: rtl/loader/download_router.sv
// download_router: download kind flags and BIOS halfword to word packing
`timescale 1ns/1ps

module download_router
	import loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  dl_stream_t  dl,
	output bios_write_t bios,
	output logic        cart_loading
);

	logic        bios_loading;      // Registered BIOS kind flag
	logic        bios_wr;
	logic [11:0] bios_addr;
	logic [31:0] bios_data;

	// ====================
	// Kind flags and write pulse
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bios_loading <= 1'b0;
			cart_loading <= 1'b0;
			bios_wr      <= 1'b0;
		end else begin
			bios_loading <= dl.active & (dl.index == 8'd0);
			// All-ones index is the code stream, neither BIOS nor cart
			cart_loading <= dl.active & ~&dl.index & |dl.index;
			bios_wr      <= bios_loading & dl.wr & dl.addr[1];  // Upper half done
		end
	end

	// Word assembly, low half first
	always_ff @(posedge clk_sys) begin
		if (bios_loading & dl.wr) begin
			if (~dl.addr[1]) begin
				bios_data[15:0] <= dl.data;     // Hold until the pair is complete
			end else begin
				bios_data[31:16] <= dl.data;
				bios_addr        <= dl.addr[13:2];  // Byte to word address
			end
		end
	end

	assign bios = '{
		addr: bios_addr,
		data: bios_data,
		wr:   bios_wr
	};

endmodule

// File: rtl/video/color_adjust.sv
// color_adjust: 5 to 8 bit colour expansion, desaturate filter, output register
`timescale 1ns/1ps

module color_adjust
	import video_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       desaturate,
	input  raster_t    raster,
	input  rgb555_t    color,
	output video_out_t video
);

	logic [7:0] r_exp, g_exp, b_exp;
	logic [7:0] luma;
	logic [7:0] r_adj, g_adj, b_adj;
	raster_t    raster_q;
	logic       de_q;
	logic [7:0] r_q, g_q, b_q;

	// Top bits repeated so full scale stays full scale
	function automatic logic [7:0] expand(input logic [4:0] c);
		return {c, c[4:2]};
	endfunction

	// Half plus quarter of the channel, plus a quarter of luma
	function automatic logic [7:0] desat(input logic [7:0] c, input logic [7:0] l);
		return {1'b0, c[7:1]} + {2'b00, c[7:2]} + {2'b00, l[7:2]};
	endfunction

	// ====================
	// Colour path
	// ====================
	always_comb begin
		r_exp = expand(color.r);
		g_exp = expand(color.g);
		b_exp = expand(color.b);
		luma  = {2'b00, r_exp[7:2]} + {1'b0, g_exp[7:1]}   // Green weighs most
		      + {3'b000, g_exp[7:3]} + {3'b000, b_exp[7:3]};
		r_adj = desaturate ? desat(r_exp, luma) : r_exp;
		g_adj = desaturate ? desat(g_exp, luma) : g_exp;
		b_adj = desaturate ? desat(b_exp, luma) : b_exp;
	end

	// Sync and blanks delayed by the same stage as the colour
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			raster_q <= '0;
			de_q     <= 1'b0;
		end else begin
			raster_q <= raster;
			de_q     <= ~(raster.hbl | raster.vbl);
		end
	end

	always_ff @(posedge clk_sys) begin
		r_q <= r_adj;
		g_q <= g_adj;
		b_q <= b_adj;
	end

	assign video = '{raster: raster_q, de: de_q, r: r_q, g: g_q, b: b_q};

endmodule

// File: rtl/video/frame_buffer.sv
// frame_buffer: 240x160 colour RAM with core write port and registered read port
`timescale 1ns/1ps
`include "gba_macros.svh"

module frame_buffer
	import video_pkg::*;
(
	input  logic         clk_sys,
	input  pixel_write_t pix_in,
	input  logic [15:0]  rd_addr,
	output rgb555_t      rd_data
);

	rgb555_t mem [`GBA_FRAME_PIXELS];   // One word per visible pixel

	// ====================
	// Write side, straight from the core
	// ====================
	always_ff @(posedge clk_sys) begin
		if (pix_in.we) begin
			mem[pix_in.addr] <= pix_in.data;
		end
	end

	// Read side, one cycle latency
	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: rtl/video/video_timing.sv
// Frame-end stretch, raster counters, sync and blank generation, framebuffer read address
`timescale 1ns/1ps
`include "gba_macros.svh"

module video_timing
	import video_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  pixel_write_t pix_in,
	input  rgb555_t      rd_data,
	output logic [15:0]  rd_addr,
	output raster_t      raster,
	output rgb555_t      color
);

	localparam int STR_W = `GBA_VSYNC_STRETCH;
	localparam int DIV_W = $clog2(`GBA_PIX_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`GBA_PIX_DIV - 1);
	localparam logic [7:0] LAST_POS = 8'(`GBA_RASTER_SIZE - 1);
	localparam logic [7:0] SCREEN_W = 8'(`GBA_SCREEN_W);
	localparam logic [7:0] SCREEN_H = 8'(`GBA_SCREEN_H);
	localparam logic [7:0] HS_START = 8'(`GBA_HS_START);
	localparam logic [7:0] HS_END   = 8'(`GBA_HS_END);
	localparam logic [7:0] VS_START = 8'(`GBA_VS_START);
	localparam logic [7:0] VS_END   = 8'(`GBA_VS_END);

	logic             frame_end;    // Core wrote the last pixel
	logic [STR_W-1:0] stretch;
	logic             vsync;        // Stretched frame-end pulse
	logic             vsync_d;
	logic             restart;      // Armed, waits for the raster corner
	logic [DIV_W-1:0] div;
	logic [7:0]       x;
	logic [7:0]       y;

	assign frame_end = pix_in.we & (pix_in.addr == 16'(`GBA_LAST_PIXEL));

	// ====================
	// Frame-end stretch
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			stretch <= '0;
			vsync   <= 1'b0;
			vsync_d <= 1'b0;
		end else begin
			stretch <= stretch << 1;
			if (frame_end) stretch <= STR_W'(1);   // Restart the shift train
			vsync   <= |stretch;
			vsync_d <= vsync;
		end
	end

	// ====================
	// Raster
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			restart <= 1'b0;
			div     <= '0;
			raster  <= '0;
			x       <= '0;
			y       <= '0;
			rd_addr <= '0;
		end else begin
			if (~vsync_d & vsync) restart <= 1'b1;
			div <= (div == DIV_LAST) ? '0 : div + 1'b1;

			raster.ce_pix <= 1'b0;
			if (div == '0) begin                 // Sample state for this step
				raster.ce_pix <= 1'b1;
				raster.hbl    <= (x >= SCREEN_W);
				if (x == HS_START) begin
					raster.hs <= 1'b1;
					if (y == VS_START) raster.vs <= 1'b1;
					if (y == VS_END)   raster.vs <= 1'b0;
				end
				if (x == HS_END)   raster.hs  <= 1'b0;
				if (y == SCREEN_H) raster.vbl <= 1'b1;
				if (y == 8'd0)     raster.vbl <= 1'b0;
			end

			if (raster.ce_pix) begin             // Advance after the step
				if (!raster.hbl && !raster.vbl) rd_addr <= rd_addr + 16'd1;
				x <= x + 8'd1;                   // Wraps to 0 at line end
				if (x == LAST_POS) begin
					if (y != LAST_POS) begin
						y <= y + 8'd1;
					end else if (restart) begin  // Otherwise free-run on the last line
						restart <= 1'b0;
						rd_addr <= '0;
						x       <= '0;
						y       <= '0;
					end
				end
			end
		end
	end

	// Colour latched on each step once the RAM read has settled
	always_ff @(posedge clk_sys) begin
		if (div == '0) color <= rd_data;
	end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_top -o tb_top_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/tb_top_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// File: sim.f
+incdir+common
common/loader_pkg.sv
common/video_pkg.sv
rtl/loader/download_router.sv
rtl/loader/cart_inspector.sv
rtl/video/frame_buffer.sv
rtl/video/video_timing.sv
rtl/video/color_adjust.sv
rtl/gba_frontend.sv
sim/tb_assert.sv
sim/tb_top.sv

// File: sim/tb_assert.sv
// tb_assert: concurrent checks on the top-level video outputs, bound into gba_frontend
`timescale 1ns/1ps

module tb_assert
	import video_pkg::*;
(
	input logic       clk_sys,
	input logic       reset,
	input video_out_t video
);

	// ====================
	// Pixel strobe
	// ====================
	// One strobe per divider period, never back to back
	ce_pix_single: assert property (@(posedge clk_sys) disable iff (reset)
		video.raster.ce_pix |=> !video.raster.ce_pix)
		else $error("ce_pix high on two consecutive cycles");

	// Data enable is the complement of both blanks on each step
	de_from_blank: assert property (@(posedge clk_sys) disable iff (reset)
		video.raster.ce_pix |-> (video.de == !(video.raster.hbl | video.raster.vbl)))
		else $error("de does not match hbl and vbl");

	// ====================
	// Sync placement
	// ====================
	hs_in_hblank: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(video.raster.hs) |-> video.raster.hbl)
		else $error("hs rose outside horizontal blank");

endmodule

bind gba_frontend tb_assert tb_assert_inst (
	.clk_sys (clk_sys),
	.reset   (reset),
	.video   (video)
);

// File: sim/tb_top.sv
// Testbench top with clock, reset, random stimulus, reference model, checks and watchdog
`timescale 1ns/1ps
`include "gba_macros.svh"

module tb_top
	import loader_pkg::*;
	import video_pkg::*;
;

	localparam int FRAME_CYCLES    = 256 * 256 * `GBA_PIX_DIV;
	localparam int WATCHDOG_CYCLES = 4 * FRAME_CYCLES + 2 * `GBA_FRAME_PIXELS + 100000;

	logic         clk_sys;
	logic         reset;
	dl_stream_t   dl;
	pixel_write_t pix_in;
	logic         desaturate;
	bios_write_t  bios;
	cart_info_t   cart;
	logic         cart_loading;
	video_out_t   video;

	logic [43:0]  bios_q[$];          // Expected {word addr, word}
	logic [43:0]  bios_entry;         // Entry popped for the current pulse
	logic [15:0]  exp_bios;           // Low halfword waiting for its pair
	logic [14:0]  fb_model [`GBA_FRAME_PIXELS];
	logic [71:0]  byte_win;           // Last nine cartridge bytes seen
	logic         cart_cond_q;        // Cart kind one cycle back
	logic         desat_mode;
	logic         in_frame;
	logic         prev_vbl;
	int           mx, my, k;
	int           hbl_cnt, hs_cnt, vbl_lines, vs_lines;
	int           frames_done;
	int           bios_words;

	gba_frontend gba_frontend_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl           (dl),
		.pix_in       (pix_in),
		.desaturate   (desaturate),
		.bios         (bios),
		.cart         (cart),
		.cart_loading (cart_loading),
		.video        (video)
	);

	always #50 clk_sys = ~clk_sys;    // 100 ns period

	// ====================
	// Failure reporting
	// ====================
	task automatic stop_with_failure();
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
		stop_with_failure();
	endtask

	task automatic report_failure(input string msg);
		$display("ERROR time=%0t %s", $time, msg);
		stop_with_failure();
	endtask

	task automatic wait_drive_slot();
		@(posedge clk_sys);
		#5;                           // Inputs move just after the edge
	endtask

	// Expansion by top-bit append, then optional desaturate
	function automatic logic [23:0] expected_rgb(input logic [14:0] c, input logic ds);
		int r, g, b, l;
		r = int'({c[14:10], c[14:12]});
		g = int'({c[9:5], c[9:7]});
		b = int'({c[4:0], c[4:2]});
		l = (r / 4 + g / 2 + g / 8 + b / 8) % 256;
		if (ds) begin
			r = (r / 2 + r / 4 + l / 4) % 256;
			g = (g / 2 + g / 4 + l / 4) % 256;
			b = (b / 2 + b / 4 + l / 4) % 256;
		end
		return {8'(r), 8'(g), 8'(b)};
	endfunction

	// ====================
	// Stimulus tasks
	// ====================
	task automatic send_bios(input int count);
		dl.index = 8'd0;
		dl.active = 1'b1;
		wait_drive_slot();
		wait_drive_slot();                // Kind flag settles
		for (int i = 0; i < count; i++) begin
			if ($urandom % 4 == 0) begin  // Random idle gap
				dl.wr = 1'b0;
				wait_drive_slot();
			end
			dl.wr = 1'b1;
			dl.addr = 27'(2 * i);
			dl.data = 16'($urandom);
			if (dl.addr[1]) begin         // Second half closes a word
				bios_q.push_back({dl.addr[13:2], dl.data, exp_bios});
			end else begin
				exp_bios = dl.data;
			end
			wait_drive_slot();
		end
		dl.wr = 1'b0;
		wait_drive_slot();
		dl.active = 1'b0;
	endtask

	// Mode 0 no marker, 1 even offset, 2 odd offset
	task automatic send_cart(input int marker_mode);
		logic [7:0]  img [160];
		logic [71:0] mark;
		logic        exp_flash;
		int          n_hw;
		int          off;
		mark = `GBA_FLASH_MARK;
		exp_flash = 1'b0;
		n_hw = 40 + int'($urandom % 40);
		for (int j = 0; j < 2 * n_hw; j++) img[j] = 8'($urandom);
		off = int'($urandom % 32'(2 * n_hw - 16));
		if (marker_mode == 1) off = off & ~1;
		if (marker_mode == 2) off = off | 1;
		if (marker_mode != 0) begin
			for (int j = 0; j < 9; j++) img[off + j] = mark[71 - 8 * j -: 8];
		end
		dl.index = 8'(1 + $urandom % 254);
		dl.active = 1'b1;
		wait_drive_slot();
		for (int i = 0; i < n_hw; i++) begin
			wait_drive_slot();
			dl.wr = 1'b1;
			dl.addr = 27'(2 * i);
			dl.data = {img[2 * i + 1], img[2 * i]};   // Low byte first
			byte_win = {byte_win[63:0], img[2 * i]};
			if (byte_win == mark) exp_flash = 1'b1;
			byte_win = {byte_win[63:0], img[2 * i + 1]};
			if (byte_win == mark) exp_flash = 1'b1;
		end
		wait_drive_slot();
		dl.wr = 1'b0;
		wait_drive_slot();
		dl.active = 1'b0;                 // Address stays on the last halfword
		repeat (4) wait_drive_slot();
		assert (cart.flash_1m == exp_flash)
			else report_mismatch("cart.flash_1m", 32'(exp_flash), 32'(cart.flash_1m));
		assert (cart.max_pak_addr == dl.addr[26:2])
			else report_mismatch("cart.max_pak_addr", 32'(dl.addr[26:2]), 32'(cart.max_pak_addr));
	endtask

	task automatic fill_frame();
		logic [14:0] c;
		for (int i = 0; i < `GBA_FRAME_PIXELS; i++) begin
			wait_drive_slot();
			c = 15'($urandom);
			fb_model[i] = c;
			pix_in.addr = 16'(i);         // Last index ends the frame
			pix_in.data = c;
			pix_in.we = 1'b1;
		end
		wait_drive_slot();
		pix_in.we = 1'b0;
	endtask

	// ====================
	// Raster model, one call per pixel step
	// ====================
	task automatic check_pixel_step();
		logic        exp_hbl, exp_hs, exp_vbl, exp_vs;
		logic [23:0] exp_rgb;
		if (!in_frame && prev_vbl && !video.raster.vbl) begin   // Restart seen
			in_frame = 1'b1;
			mx = 0;
			my = 0;
			k = 0;
			vbl_lines = 0;
			vs_lines = 0;
		end
		prev_vbl = video.raster.vbl;
		if (!in_frame) return;
		exp_hbl = (mx >= `GBA_SCREEN_W);
		exp_hs  = (mx >= `GBA_HS_START) && (mx < `GBA_HS_END);
		exp_vbl = (my >= `GBA_SCREEN_H);
		exp_vs  = (my > `GBA_VS_START && my < `GBA_VS_END)
		       || (my == `GBA_VS_START && mx >= `GBA_HS_START)
		       || (my == `GBA_VS_END && mx < `GBA_HS_START);   // vs moves at hs start
		assert (video.raster.hbl == exp_hbl)
			else report_mismatch("video.raster.hbl", 32'(exp_hbl), 32'(video.raster.hbl));
		assert (video.raster.hs == exp_hs)
			else report_mismatch("video.raster.hs", 32'(exp_hs), 32'(video.raster.hs));
		assert (video.raster.vbl == exp_vbl)
			else report_mismatch("video.raster.vbl", 32'(exp_vbl), 32'(video.raster.vbl));
		assert (video.raster.vs == exp_vs)
			else report_mismatch("video.raster.vs", 32'(exp_vs), 32'(video.raster.vs));
		assert (video.de == (!exp_hbl && !exp_vbl))
			else report_mismatch("video.de", 32'(!exp_hbl && !exp_vbl), 32'(video.de));
		if (!exp_hbl && !exp_vbl) begin
			exp_rgb = expected_rgb(fb_model[k], desat_mode);
			assert ({video.r, video.g, video.b} == exp_rgb)
				else report_mismatch("video.rgb", 32'(exp_rgb), 32'({video.r, video.g, video.b}));
			k++;
		end
		hbl_cnt = (mx == 0 ? 0 : hbl_cnt) + (video.raster.hbl ? 1 : 0);
		hs_cnt  = (mx == 0 ? 0 : hs_cnt) + (video.raster.hs ? 1 : 0);
		if (mx == 0 && video.raster.vbl) vbl_lines++;
		if (mx == `GBA_HS_START && video.raster.vs) vs_lines++;
		if (mx == 255) begin              // Line shape
			assert (hbl_cnt == 16) else report_mismatch("hbl steps", 32'd16, 32'(hbl_cnt));
			assert (hs_cnt == 8) else report_mismatch("hs steps", 32'd8, 32'(hs_cnt));
		end
		if (mx == 255 && my == 255) begin // Frame shape
			assert (vbl_lines == 96) else report_mismatch("vbl lines", 32'd96, 32'(vbl_lines));
			assert (vs_lines == 3) else report_mismatch("vs lines", 32'd3, 32'(vs_lines));
			in_frame = 1'b0;
			frames_done++;
		end
		my = (mx == 255) ? my + 1 : my;
		mx = (mx + 1) % 256;
	endtask

	// Outputs sampled mid-cycle away from both edges
	always @(negedge clk_sys) begin
		if (!reset) begin
			assert (cart_loading == cart_cond_q)
				else report_mismatch("cart_loading", 32'(cart_cond_q), 32'(cart_loading));
			if (bios.wr) begin
				if (bios_q.size() == 0) report_failure("BIOS write pulse without a halfword pair");
				bios_entry = bios_q.pop_front();
				assert (bios.addr == bios_entry[43:32])
					else report_mismatch("bios.addr", 32'(bios_entry[43:32]), 32'(bios.addr));
				assert (bios.data == bios_entry[31:0])
					else report_mismatch("bios.data", bios_entry[31:0], bios.data);
				bios_words++;
			end
			if (video.raster.ce_pix) check_pixel_step();
		end
		cart_cond_q = dl.active & (dl.index != 8'd0) & (dl.index != 8'hff);
	end

	// ====================
	// Main sequence and watchdog
	// ====================
	initial begin
		void'($urandom(91808));
		clk_sys = 1'b0;
		reset = 1'b1;
		dl = '0;
		pix_in = '0;
		desaturate = 1'b0;
		desat_mode = 1'b0;
		byte_win = '0;
		exp_bios = '0;
		bios_entry = '0;
		cart_cond_q = 1'b0;
		in_frame = 1'b0;
		prev_vbl = 1'b0;
		frames_done = 0;
		bios_words = 0;
		repeat (16) @(posedge clk_sys);
		#5;
		reset = 1'b0;
		send_bios(64);
		repeat (8) wait_drive_slot();
		send_cart(0);
		send_cart(1);
		send_cart(2);
		send_cart(1);
		send_cart(2);
		send_cart(0);
		fill_frame();
		wait (frames_done == 1);
		wait_drive_slot();
		desaturate = 1'b1;                // Raster parked on the last line
		desat_mode = 1'b1;
		fill_frame();
		wait (frames_done == 2);
		if (bios_words != 32 || bios_q.size() != 0) begin
			report_failure("BIOS word count differs from halfword pairs sent");
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * 100);
		report_failure("watchdog expired before both frames were checked");
	end

endmodule
